/* include/ps2_kbd_config.svh */
`ifndef PS2_KBD_CONFIG_SVH
`define PS2_KBD_CONFIG_SVH

// scan code buffer entries, keep a power of two
`define PS2_FIFO_DEPTH 8

// flops on the ps2_clk input
`define PS2_SYNC_STAGES 3

// prefix bytes of the set 2 scan codes
`define PS2_EXT_PREFIX 8'hE0
`define PS2_BREAK_PREFIX 8'hF0

`endif

/* logic/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

  // one byte as it comes off the wire
  typedef logic [7:0] scan_code_t;

  // one hex digit of a display
  typedef logic [3:0] nibble_t;

  // segment lines, bit 6 is a and bit 0 is g
  // active low for common anode parts
  typedef logic [6:0] seg_t;

endpackage

/* logic/ps2_frame_rx.sv */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_frame_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ps2_clk,
  input  logic                    ps2_data,
  output ps2_kbd_pkg::scan_code_t code,
  output logic                    code_valid,
  output logic                    frame_error
);
  import ps2_kbd_pkg::*;

  localparam int SYNC_W = `PS2_SYNC_STAGES;

  logic [SYNC_W-1:0] clk_sync;     // oldest sample in the msb
  logic              fall;         // synchronized falling edge
  logic [3:0]        bit_cnt;      // 0 start .. 10 stop
  logic [9:0]        shift_q;      // start, data, parity
  scan_code_t        frame_byte;
  logic              frame_ok;

  // line idles high, so reset the chain to ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync <= '1;
    end else begin
      clk_sync <= {clk_sync[SYNC_W-2:0], ps2_clk};
    end
  end

  assign fall = clk_sync[SYNC_W-1] & ~clk_sync[SYNC_W-2];

  // bits arrive lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (fall && bit_cnt != 4'd10) begin
      shift_q <= {ps2_data, shift_q[9:1]};
    end
  end

  assign frame_byte = shift_q[8:1];

  // start low, stop high (still on the line), odd parity over data and parity
  assign frame_ok = ~shift_q[0] & ps2_data & (^shift_q[9:1]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      code_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      code_valid <= 1'b0;                // single cycle strobe
      if (fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt <= '0;                 // ready for next frame
          if (frame_ok) begin
            code_valid <= 1'b1;
          end else begin
            frame_error <= 1'b1;         // sticky
          end
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // byte held until the next good frame
  always_ff @(posedge clk) begin
    if (fall && bit_cnt == 4'd10 && frame_ok) begin
      code <= frame_byte;
    end
  end

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module sync_fifo #(
  parameter type payload_t = ps2_kbd_pkg::scan_code_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr,
  input  payload_t wr_data,
  input  logic     rd,
  output payload_t data,
  output logic     ready,
  output logic     overflow
);

  localparam int DEPTH  = `PS2_FIFO_DEPTH;
  localparam int ADDR_W = $clog2(DEPTH);

  payload_t          mem [DEPTH];
  logic [ADDR_W:0]   wr_ptr;       // extra msb tells full from empty
  logic [ADDR_W:0]   rd_ptr;
  logic              empty;
  logic              full;
  logic              do_wr;
  logic              do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign do_wr = wr & ~full;       // full means the byte is lost
  assign do_rd = rd & ~empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr && full) begin
        overflow <= 1'b1;          // stays until reset
      end
    end
  end

  // head entry always on the output
  assign data  = mem[rd_ptr[ADDR_W-1:0]];
  assign ready = ~empty;

endmodule

/* logic/key_event_tracker.sv */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module key_event_tracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    hold,
  input  logic                    ready,
  input  ps2_kbd_pkg::scan_code_t data,
  output logic                    rd,
  output ps2_kbd_pkg::scan_code_t key_code,
  output logic                    extended,
  output logic                    key_down,
  output logic [7:0]              press_count,
  output logic                    key_valid
);
  import ps2_kbd_pkg::*;

  localparam scan_code_t EXT_CODE = `PS2_EXT_PREFIX;
  localparam scan_code_t BRK_CODE = `PS2_BREAK_PREFIX;

  logic ext_pend;                  // E0 seen, key byte not yet
  logic brk_pend;                  // F0 seen, key byte not yet
  logic is_ext;
  logic is_brk;
  logic is_key;

  // pop whenever something is waiting and the display is live
  assign rd = ready & ~hold;

  assign is_ext = (data == EXT_CODE);
  assign is_brk = (data == BRK_CODE);
  assign is_key = ~is_ext & ~is_brk;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_pend <= 1'b0;
      brk_pend <= 1'b0;
    end else if (rd) begin
      if (is_key) begin
        ext_pend <= 1'b0;          // event done, forget prefixes
        brk_pend <= 1'b0;
      end else begin
        if (is_ext) begin
          ext_pend <= 1'b1;
        end
        if (is_brk) begin
          brk_pend <= 1'b1;
        end
      end
    end
  end

  // outputs move only on the final byte of a sequence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_code    <= '0;
      extended    <= 1'b0;
      key_down    <= 1'b0;
      press_count <= '0;
      key_valid   <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (rd && is_key) begin
        key_code  <= data;
        extended  <= ext_pend;
        key_down  <= ~brk_pend;
        key_valid <= 1'b1;
        if (!brk_pend) begin
          press_count <= press_count + 8'd1;   // wraps at 256, repeats count too
        end
      end
    end
  end

endmodule

/* logic/hex_seg_decoder.sv */
`timescale 1ns/1ps

module hex_seg_decoder (
  input  ps2_kbd_pkg::nibble_t digit,
  output ps2_kbd_pkg::seg_t    seg
);
  import ps2_kbd_pkg::*;

  seg_t seg_on;                    // active high, a in bit 6

  always_comb begin
    case (digit)
      4'h0:    seg_on = 7'b1111110;
      4'h1:    seg_on = 7'b0110000;
      4'h2:    seg_on = 7'b1101101;
      4'h3:    seg_on = 7'b1111001;
      4'h4:    seg_on = 7'b0110011;
      4'h5:    seg_on = 7'b1011011;
      4'h6:    seg_on = 7'b1011111;
      4'h7:    seg_on = 7'b1110000;
      4'h8:    seg_on = 7'b1111111;
      4'h9:    seg_on = 7'b1111011;
      4'hA:    seg_on = 7'b1110111;
      4'hB:    seg_on = 7'b0011111;   // lower case b
      4'hC:    seg_on = 7'b1001110;
      4'hD:    seg_on = 7'b0111101;   // lower case d
      4'hE:    seg_on = 7'b1001111;
      default: seg_on = 7'b1000111;   // F
    endcase
  end

  // common anode board, segment lit when low
  assign seg = ~seg_on;

endmodule

/* logic/ps2_kbd_top.sv */
`timescale 1ns/1ps

module ps2_kbd_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ps2_clk,
  input  logic               ps2_data,
  input  logic               hold,
  output ps2_kbd_pkg::seg_t  hex0,
  output ps2_kbd_pkg::seg_t  hex1,
  output ps2_kbd_pkg::seg_t  hex2,
  output ps2_kbd_pkg::seg_t  hex3,
  output logic               key_down,
  output logic               extended,
  output logic               key_valid,
  output logic               overflow,
  output logic               frame_error
);
  import ps2_kbd_pkg::*;

  scan_code_t rx_code;
  logic       rx_valid;
  scan_code_t fifo_data;
  logic       fifo_ready;
  logic       fifo_rd;
  scan_code_t key_code;
  logic [7:0] press_count;
  nibble_t    code_lo;
  nibble_t    code_hi;
  nibble_t    cnt_lo;
  nibble_t    cnt_hi;

  ps2_frame_rx u_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .code        (rx_code),
    .code_valid  (rx_valid),
    .frame_error (frame_error)
  );

  sync_fifo #(
    .payload_t (scan_code_t)
  ) u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (rx_valid),
    .wr_data  (rx_code),
    .rd       (fifo_rd),
    .data     (fifo_data),
    .ready    (fifo_ready),
    .overflow (overflow)
  );

  key_event_tracker u_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .hold        (hold),
    .ready       (fifo_ready),
    .data        (fifo_data),
    .rd          (fifo_rd),
    .key_code    (key_code),
    .extended    (extended),
    .key_down    (key_down),
    .press_count (press_count),
    .key_valid   (key_valid)
  );

  // hex1:hex0 key code, hex3:hex2 press count
  assign code_lo = key_code[3:0];
  assign code_hi = key_code[7:4];
  assign cnt_lo  = press_count[3:0];
  assign cnt_hi  = press_count[7:4];

  hex_seg_decoder u_hex0 (.digit(code_lo), .seg(hex0));
  hex_seg_decoder u_hex1 (.digit(code_hi), .seg(hex1));
  hex_seg_decoder u_hex2 (.digit(cnt_lo),  .seg(hex2));
  hex_seg_decoder u_hex3 (.digit(cnt_hi),  .seg(hex3));

endmodule

/* dv/ps2_device_bfm.sv */
`timescale 1ns/1ps

module ps2_device_bfm #(
  parameter int HALF_PERIOD = 20          // system clocks per ps2_clk phase
) (
  input  logic       clk,
  input  logic       start,
  input  logic [7:0] tx_byte,
  input  logic       bad_parity,
  output logic       ps2_clk,
  output logic       ps2_data,
  output logic       busy
);

  logic [10:0] frame;

  task automatic send_frame();
    logic parity;
    int   i;
    parity = ~(^tx_byte);                 // odd over data plus parity
    if (bad_parity) begin
      parity = ~parity;
    end
    frame = {1'b1, parity, tx_byte, 1'b0}; // stop, parity, data, start
    busy <= 1'b1;
    for (i = 0; i < 11; i++) begin
      ps2_data <= frame[i];               // set up while ps2_clk is high
      repeat (HALF_PERIOD) @(posedge clk);
      ps2_clk <= 1'b0;                    // host samples on this edge
      repeat (HALF_PERIOD) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (HALF_PERIOD) @(posedge clk);  // stop bit left on the line
    busy <= 1'b0;
  endtask

  initial begin
    ps2_clk  = 1'b1;                      // bus idles high
    ps2_data = 1'b1;
    busy     = 1'b0;
    forever begin
      @(posedge clk);
      if (start) begin
        send_frame();
      end
    end
  end

endmodule

/* dv/ps2_kbd_tb.sv */
`timescale 1ns/1ps
`include "ps2_kbd_config.svh"

module ps2_kbd_tb;
  import ps2_kbd_pkg::*;

  localparam int NUM_ROWS      = 8;
  localparam int DEPTH         = `PS2_FIFO_DEPTH;
  localparam int EVENT_TIMEOUT = 3000;    // cycles
  localparam int QUIET_CYCLES  = 150;

  typedef struct {
    string       name;
    logic [71:0] seq;                     // first byte in the top used bits
    int          len;
    logic        bad_par;
    logic        hold;
    int          events;
    logic [7:0]  exp_code;
    logic        exp_ext;
    logic        exp_down;
    logic [7:0]  exp_count;
    logic        exp_ovf;
    logic        exp_ferr;
  } test_row_t;

  logic        clk;
  logic        rst_n;
  logic        hold;
  logic        start;
  logic [7:0]  tx_byte;
  logic        bad_parity;
  logic        ps2_clk;
  logic        ps2_data;
  logic        busy;
  seg_t        hex0;
  seg_t        hex1;
  seg_t        hex2;
  seg_t        hex3;
  logic        key_down;
  logic        extended;
  logic        key_valid;
  logic        overflow;
  logic        frame_error;
  test_row_t   rows [NUM_ROWS];
  logic [13:0] ev_seg_q [$];              // hex1:hex0 at each key event
  int          row_errors;
  int          passed;
  int          failed;

  ps2_device_bfm #(.HALF_PERIOD(20)) u_bfm (
    .clk        (clk),
    .start      (start),
    .tx_byte    (tx_byte),
    .bad_parity (bad_parity),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .busy       (busy)
  );

  ps2_kbd_top u_ps2_kbd_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .hold        (hold),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .key_down    (key_down),
    .extended    (extended),
    .key_valid   (key_valid),
    .overflow    (overflow),
    .frame_error (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n && key_valid) begin
      ev_seg_q.push_back({hex1, hex0});
    end
  end

  // active low patterns, segment a in bit 6
  function automatic seg_t seg_of(input logic [3:0] n);
    case (n)
      4'h0: return 7'b0000001;
      4'h1: return 7'b1001111;
      4'h2: return 7'b0010010;
      4'h3: return 7'b0000110;
      4'h4: return 7'b1001100;
      4'h5: return 7'b0100100;
      4'h6: return 7'b0100000;
      4'h7: return 7'b0001111;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0000100;
      4'hA: return 7'b0001000;
      4'hB: return 7'b1100000;
      4'hC: return 7'b0110001;
      4'hD: return 7'b1000010;
      4'hE: return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  function automatic logic [13:0] byte_segs(input logic [7:0] b);
    return {seg_of(b[7:4]), seg_of(b[3:0])};
  endfunction

  function automatic logic [7:0] byte_at(input test_row_t r, input int i);
    return r.seq[8*(r.len-1-i) +: 8];
  endfunction

  function automatic logic is_prefix(input logic [7:0] b);
    return (b == `PS2_EXT_PREFIX) || (b == `PS2_BREAK_PREFIX);
  endfunction

  task automatic compare_field(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", name, what, exp, act);
      row_errors++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input logic corrupt, input string name);
    int n;
    @(posedge clk);
    tx_byte    <= b;
    bad_parity <= corrupt;
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (!busy && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!busy) begin
      $display("%s: the keyboard model never started its frame", name);
      row_errors++;
    end
    n = 0;
    while (busy && n < 1000) begin
      @(posedge clk);
      n++;
    end
    if (busy) begin
      $display("%s: the keyboard model did not finish its frame in time", name);
      row_errors++;
    end
    repeat (10 + $urandom % 30) @(posedge clk);   // idle gap between frames
  endtask

  task automatic run_row(input test_row_t r);
    int         i;
    int         k;
    int         n;
    logic [7:0] b;
    row_errors = 0;
    ev_seg_q.delete();
    @(posedge clk);
    hold <= r.hold;
    for (i = 0; i < r.len; i++) begin
      send_byte(byte_at(r, i), r.bad_par, r.name);
    end
    if (r.hold) begin
      compare_field(r.name, "events while held", 32'd0, ev_seg_q.size());
      compare_field(r.name, "overflow while held", r.exp_ovf, overflow);
      @(posedge clk);
      hold <= 1'b0;
    end
    n = 0;
    while (ev_seg_q.size() < r.events && n < EVENT_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (ev_seg_q.size() < r.events) begin
      $display("%s: the expected key events did not arrive before the timeout", r.name);
      row_errors++;
    end
    repeat (QUIET_CYCLES) @(posedge clk);         // no extra events allowed
    compare_field(r.name, "event count", r.events, ev_seg_q.size());
    k = 0;
    for (i = 0; i < r.len && k < r.events && k < ev_seg_q.size(); i++) begin
      b = byte_at(r, i);
      if (!is_prefix(b)) begin
        compare_field(r.name, "event code", byte_segs(b), ev_seg_q[k]);
        k++;
      end
    end
    compare_field(r.name, "hex1:hex0", byte_segs(r.exp_code), {hex1, hex0});
    compare_field(r.name, "hex3:hex2", byte_segs(r.exp_count), {hex3, hex2});
    compare_field(r.name, "key_down", r.exp_down, key_down);
    compare_field(r.name, "extended", r.exp_ext, extended);
    compare_field(r.name, "overflow", r.exp_ovf, overflow);
    compare_field(r.name, "frame_error", r.exp_ferr, frame_error);
    if (row_errors == 0) begin
      passed++;
      $display("test %s: ok", r.name);
    end else begin
      failed++;
      $display("test %s: %0d errors", r.name, row_errors);
    end
  endtask

  task automatic fill_rows();
    rows[0] = '{"reset_state", 72'h0, 0, 1'b0, 1'b0, 0,
                8'h00, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0};
    rows[1] = '{"make_1c", 72'h1C, 1, 1'b0, 1'b0, 1,
                8'h1C, 1'b0, 1'b1, 8'd1, 1'b0, 1'b0};
    rows[2] = '{"break_1c", 72'({`PS2_BREAK_PREFIX, 8'h1C}), 2, 1'b0, 1'b0, 1,
                8'h1C, 1'b0, 1'b0, 8'd1, 1'b0, 1'b0};
    rows[3] = '{"ext_make_75", 72'({`PS2_EXT_PREFIX, 8'h75}), 2, 1'b0, 1'b0, 1,
                8'h75, 1'b1, 1'b1, 8'd2, 1'b0, 1'b0};
    rows[4] = '{"ext_break_75", 72'({`PS2_EXT_PREFIX, `PS2_BREAK_PREFIX, 8'h75}), 3,
                1'b0, 1'b0, 1, 8'h75, 1'b1, 1'b0, 8'd2, 1'b0, 1'b0};
    rows[5] = '{"bad_parity", 72'h32, 1, 1'b1, 1'b0, 0,
                8'h75, 1'b1, 1'b0, 8'd2, 1'b0, 1'b1};
    rows[6] = '{"after_error", 72'h32, 1, 1'b0, 1'b0, 1,
                8'h32, 1'b0, 1'b1, 8'd3, 1'b0, 1'b1};
    rows[7] = '{"hold_overflow", 72'h151D242D2C353C4344, DEPTH + 1, 1'b0, 1'b1, DEPTH,
                8'h43, 1'b0, 1'b1, 8'(3 + DEPTH), 1'b1, 1'b1};
  endtask

  initial begin
    int t;
    void'($urandom(32'hdda01b49));
    rst_n      = 1'b0;
    hold       = 1'b0;
    start      = 1'b0;
    tx_byte    = 8'h00;
    bad_parity = 1'b0;
    passed     = 0;
    failed     = 0;
    fill_rows();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (t = 0; t < NUM_ROWS; t++) begin
      run_row(rows[t]);
    end
    $display("tests passed: %0d, tests failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* ps2_kbd.f */
+incdir+include
logic/ps2_kbd_pkg.sv
logic/ps2_frame_rx.sv
logic/sync_fifo.sv
logic/key_event_tracker.sv
logic/hex_seg_decoder.sv
logic/ps2_kbd_top.sv
dv/ps2_device_bfm.sv
dv/ps2_kbd_tb.sv

/* Makefile */
TOP := ps2_kbd_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f ps2_kbd.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf obj_dir
